// ==== mips_pipe.f ====
mips_isa_pkg.sv
pipe_pkg.sv
forward_unit.sv
reg_file.sv
decode_stage.sv
exec_stage.sv
mem_array.sv
mips_pipe.sv
tb_mips_pipe.sv

// ==== Makefile ====
VERILATOR  ?= verilator
TOP        ?= tb_mips_pipe
RTL_TOP    ?= mips_pipe
FILELIST   ?= mips_pipe.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal
LINT_FLAGS ?= --lint-only --timing -Wall

SOURCES := $(shell cat $(FILELIST))
BIN     := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(RTL_TOP)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	cat $(LOG)
	@if grep -q '\*\*\* FAILED \*\*\*' $(LOG); then exit 1; fi
	@grep -q '\*\*\* PASSED \*\*\*' $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== tb_mips_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module tb_mips_pipe;

	localparam int IMEM_DEPTH = 64;
	localparam int DMEM_DEPTH = 64;
	localparam int DMEM_AW    = $clog2(DMEM_DEPTH);
	localparam int CLK_PERIOD = 40;
	localparam int RUN_ALU    = 20;
	localparam int RUN_BYPASS = 18;
	localparam int RUN_LOAD   = 14;
	localparam int RUN_COPY   = 16;
	localparam int RUN_ZERO   = 14;
	localparam int RUN_RAND   = 60;
	// Each test spends its run length in reset and again running
	localparam int BUDGET = 2 * (RUN_ALU + RUN_BYPASS + RUN_LOAD + RUN_COPY + RUN_ZERO
		+ RUN_RAND) + 20;

	localparam logic [5:0] OP_R    = 6'h00;
	localparam logic [5:0] OP_ADDI = 6'h08;
	localparam logic [5:0] OP_LW   = 6'h23;
	localparam logic [5:0] OP_SW   = 6'h2b;
	localparam logic [5:0] FN_ADD  = 6'h20;
	localparam logic [5:0] FN_SUB  = 6'h22;
	localparam logic [5:0] FN_AND  = 6'h24;
	localparam logic [5:0] FN_OR   = 6'h25;
	localparam logic [5:0] FN_SLT  = 6'h2a;

	typedef struct packed {
		logic [4:0]  dest;
		logic [31:0] data;
	} wb_rec_t;

	typedef struct packed {
		logic [31:0] addr;
		logic [31:0] data;
	} st_rec_t;

	logic        clk;
	logic        arst_n;
	logic        prog_we;
	logic [29:0] prog_addr;
	logic [31:0] prog_data;
	logic        wb_valid;
	logic [4:0]  wb_dest;
	logic [31:0] wb_data;
	logic        st_valid;
	logic [31:0] st_addr;
	logic [31:0] st_data;

	logic [31:0] prog [IMEM_DEPTH];
	int          prog_len;
	logic [31:0] ref_regs [32];
	logic [31:0] ref_mem [DMEM_DEPTH];
	logic        ref_mem_valid [DMEM_DEPTH];    // Words the DUT memory really holds
	wb_rec_t     exp_wb [$];
	st_rec_t     exp_st [$];
	int          wb_cycles [$];
	int          err_count;
	logic [31:0] lfsr;

	mips_pipe #(.IMEM_DEPTH(IMEM_DEPTH), .DMEM_DEPTH(DMEM_DEPTH)) UUT (
		.clk       (clk),
		.arst_n    (arst_n),
		.prog_we   (prog_we),
		.prog_addr (prog_addr),
		.prog_data (prog_data),
		.wb_valid  (wb_valid),
		.wb_dest   (wb_dest),
		.wb_data   (wb_data),
		.st_valid  (st_valid),
		.st_addr   (st_addr),
		.st_data   (st_data)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	initial
	begin
		#(5 * BUDGET * CLK_PERIOD);
		$display("watchdog: run did not finish within %0d cycles", 5 * BUDGET);
		$display("*** FAILED ***");
		$finish;
	end

	// Taps 32, 22, 2, 1
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	task automatic draw_bits(input int n, output logic [31:0] v);
		v = '0;
		for (int i = 0; i < n; i++)
		begin
			lfsr = lfsr_next(lfsr);
			v    = {v[30:0], lfsr[0]};
		end
	endtask

	function automatic logic [31:0] r_instr(input logic [5:0] fn, input logic [4:0] rd,
		input logic [4:0] rs, input logic [4:0] rt);
		return {OP_R, rs, rt, rd, 5'd0, fn};
	endfunction

	function automatic logic [31:0] i_instr(input logic [5:0] op, input logic [4:0] rt,
		input logic [4:0] rs, input logic [15:0] imm);
		return {op, rs, rt, imm};
	endfunction

	task automatic push_instr(input logic [31:0] w);
		prog[prog_len] = w;
		prog_len++;
	endtask

	// Sequential execution, one instruction at a time
	task automatic model_program();
		logic [31:0] w;
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] imm;
		logic [31:0] val;
		logic [31:0] addr;
		logic [4:0]  dest;
		logic        write;
		int          idx;
		exp_wb.delete();
		exp_st.delete();
		for (int r = 0; r < 32; r++)
			ref_regs[r] = '0;
		for (int i = 0; i < prog_len; i++)
		begin
			w     = prog[i];
			a     = ref_regs[w[25:21]];
			b     = ref_regs[w[20:16]];
			imm   = {{16{w[15]}}, w[15:0]};
			addr  = a + imm;
			idx   = int'(addr[31:2]);
			write = 1'b1;
			dest  = w[20:16];
			val   = '0;
			case (w[31:26])
				OP_R:
				begin
					dest = w[15:11];
					case (w[5:0])
						FN_ADD:  val = a + b;
						FN_SUB:  val = a - b;
						FN_AND:  val = a & b;
						FN_OR:   val = a | b;
						FN_SLT:  val = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
						default: write = 1'b0;
					endcase
				end
				OP_ADDI: val = a + imm;
				OP_LW:
				begin
					if (!ref_mem_valid[idx])
					begin
						$display("program loads data word %0d that was never stored", idx);
						err_count++;
					end
					val = ref_mem[idx];
				end
				OP_SW:
				begin
					write              = 1'b0;
					ref_mem[idx]       = b;
					ref_mem_valid[idx] = 1'b1;
					exp_st.push_back(st_rec_t'{addr: addr, data: b});
				end
				default: write = 1'b0;
			endcase
			if (write && dest != 5'd0)
			begin
				ref_regs[dest] = val;
				exp_wb.push_back(wb_rec_t'{dest: dest, data: val});
			end
		end
	endtask

	task automatic check_traces(input string name, input int cycle);
		wb_rec_t wr;
		st_rec_t sr;
		if (wb_valid === 1'b1)
		begin
			if (exp_wb.size() == 0)
			begin
				$display("test %s: writeback to r%0d when none was expected", name, wb_dest);
				err_count++;
			end
			else
			begin
				wr = exp_wb.pop_front();
				wb_cycles.push_back(cycle);
				if (wb_dest !== wr.dest)
				begin
					$display("FAIL %s: wb_dest expected %0d, actual %0d", name, wr.dest, wb_dest);
					err_count++;
				end
				if (wb_data !== wr.data)
				begin
					$display("FAIL %s: wb_data expected %h, actual %h", name, wr.data, wb_data);
					err_count++;
				end
			end
		end
		if (st_valid === 1'b1)
		begin
			if (exp_st.size() == 0)
			begin
				$display("test %s: store to %h when none was expected", name, st_addr);
				err_count++;
			end
			else
			begin
				sr = exp_st.pop_front();
				if (st_addr !== sr.addr || st_data !== sr.data)
				begin
					$display("FAIL %s: store expected %h <- %h, actual %h <- %h",
						name, sr.addr, sr.data, st_addr, st_data);
					err_count++;
				end
			end
		end
	endtask

	// Program words go in while reset is held, then the pipe runs
	task automatic reset_and_run(input string name, input int run_cycles);
		int load_cycles;
		load_cycles = (run_cycles > 5) ? run_cycles : 5;
		model_program();
		wb_cycles.delete();
		@(negedge clk);
		arst_n = 1'b0;
		for (int i = 0; i < load_cycles; i++)
		begin
			prog_we   = (i < run_cycles);
			prog_addr = 30'(i);
			prog_data = (i < prog_len) ? prog[i] : 32'h0;    // nop padding
			@(negedge clk);
		end
		prog_we = 1'b0;
		arst_n  = 1'b1;
		for (int i = 0; i < run_cycles; i++)
		begin
			@(negedge clk);
			check_traces(name, i);
		end
		if (exp_wb.size() != 0)
		begin
			$display("test %s: %0d expected writebacks never appeared", name, exp_wb.size());
			err_count++;
		end
		if (exp_st.size() != 0)
		begin
			$display("test %s: %0d expected stores never appeared", name, exp_st.size());
			err_count++;
		end
	endtask

	task automatic alu_forwarding();
		prog_len = 0;
		push_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'd5));
		push_instr(i_instr(OP_ADDI, 5'd2, 5'd0, 16'd7));
		push_instr(r_instr(FN_ADD, 5'd3, 5'd1, 5'd2));    // EX/MEM and MEM/WB
		push_instr(r_instr(FN_SUB, 5'd4, 5'd3, 5'd1));
		push_instr(r_instr(FN_AND, 5'd5, 5'd3, 5'd4));
		push_instr(r_instr(FN_OR, 5'd6, 5'd5, 5'd2));
		push_instr(r_instr(FN_SLT, 5'd7, 5'd1, 5'd4));
		push_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'd1));
		push_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'd2));
		push_instr(r_instr(FN_ADD, 5'd2, 5'd1, 5'd1));    // Newest r1 must win
		push_instr(i_instr(OP_ADDI, 5'd3, 5'd2, 16'hfffd));
		reset_and_run("alu_forwarding", RUN_ALU);
	endtask

	task automatic decode_bypass();
		prog_len = 0;
		push_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'd11));
		push_instr(32'h0);
		push_instr(32'h0);
		push_instr(r_instr(FN_ADD, 5'd2, 5'd1, 5'd1));    // rs and rt bypassed
		push_instr(i_instr(OP_ADDI, 5'd4, 5'd0, 16'd9));
		push_instr(32'h0);
		push_instr(32'h0);
		push_instr(r_instr(FN_SUB, 5'd5, 5'd2, 5'd4));
		push_instr(r_instr(FN_OR, 5'd6, 5'd4, 5'd1));
		reset_and_run("decode_bypass", RUN_BYPASS);
	endtask

	task automatic load_use_stall();
		prog_len = 0;
		push_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'd77));
		push_instr(i_instr(OP_SW, 5'd1, 5'd0, 16'd8));
		push_instr(i_instr(OP_LW, 5'd2, 5'd0, 16'd8));
		push_instr(r_instr(FN_ADD, 5'd3, 5'd2, 5'd1));
		push_instr(r_instr(FN_SUB, 5'd4, 5'd3, 5'd2));
		reset_and_run("load_use_stall", RUN_LOAD);
		if (wb_cycles.size() != 4)
		begin
			$display("test load_use_stall: %0d writebacks seen instead of 4", wb_cycles.size());
			err_count++;
		end
		else
		begin
			if (wb_cycles[2] - wb_cycles[1] != 2)
			begin
				$display("FAIL load_use_stall: load to user gap expected 2, actual %0d",
					wb_cycles[2] - wb_cycles[1]);
				err_count++;
			end
			if (wb_cycles[3] - wb_cycles[2] != 1)
			begin
				$display("FAIL load_use_stall: user to next gap expected 1, actual %0d",
					wb_cycles[3] - wb_cycles[2]);
				err_count++;
			end
		end
	endtask

	task automatic load_store_copy();
		prog_len = 0;
		push_instr(i_instr(OP_ADDI, 5'd1, 5'd0, 16'h1234));
		push_instr(i_instr(OP_SW, 5'd1, 5'd0, 16'd12));
		push_instr(i_instr(OP_LW, 5'd2, 5'd0, 16'd12));
		push_instr(i_instr(OP_SW, 5'd2, 5'd0, 16'd16));    // Copy of the loaded word
		push_instr(i_instr(OP_LW, 5'd3, 5'd0, 16'd16));
		push_instr(r_instr(FN_ADD, 5'd4, 5'd3, 5'd1));
		reset_and_run("load_store_copy", RUN_COPY);
	endtask

	task automatic zero_register();
		prog_len = 0;
		push_instr(i_instr(OP_ADDI, 5'd0, 5'd0, 16'd55));
		push_instr(i_instr(OP_SW, 5'd0, 5'd0, 16'd20));
		push_instr(r_instr(FN_ADD, 5'd1, 5'd0, 5'd0));
		push_instr(i_instr(OP_ADDI, 5'd2, 5'd0, 16'd3));
		push_instr(r_instr(FN_ADD, 5'd0, 5'd2, 5'd2));
		push_instr(r_instr(FN_OR, 5'd3, 5'd0, 5'd2));    // Must not see 6
		push_instr(r_instr(FN_SLT, 5'd4, 5'd0, 5'd2));
		reset_and_run("zero_register", RUN_ZERO);
	endtask

	task automatic random_program();
		logic [31:0] kind;
		logic [31:0] ra;
		logic [31:0] rb;
		logic [31:0] rc;
		logic [31:0] v;
		logic        written [DMEM_DEPTH];
		int          idx;
		prog_len = 0;
		for (int i = 0; i < DMEM_DEPTH; i++)
			written[i] = ref_mem_valid[i];
		for (int n = 0; n < 24; n++)
		begin
			draw_bits(3, kind);
			draw_bits(3, ra);
			draw_bits(3, rb);
			draw_bits(3, rc);
			case (kind[2:0])
				3'd0: push_instr(r_instr(FN_ADD, ra[4:0], rb[4:0], rc[4:0]));
				3'd1: push_instr(r_instr(FN_SUB, ra[4:0], rb[4:0], rc[4:0]));
				3'd2: push_instr(r_instr(FN_AND, ra[4:0], rb[4:0], rc[4:0]));
				3'd3: push_instr(r_instr(FN_OR, ra[4:0], rb[4:0], rc[4:0]));
				3'd4: push_instr(r_instr(FN_SLT, ra[4:0], rb[4:0], rc[4:0]));
				3'd5:
				begin
					draw_bits(16, v);
					push_instr(i_instr(OP_ADDI, ra[4:0], rb[4:0], v[15:0]));
				end
				default:
				begin
					draw_bits(DMEM_AW, v);
					idx = int'(v) % DMEM_DEPTH;
					// Loads only from words that hold data
					if (kind[2:0] == 3'd7 || !written[idx])
					begin
						push_instr(i_instr(OP_SW, ra[4:0], 5'd0, 16'(idx * 4)));
						written[idx] = 1'b1;
					end
					else
						push_instr(i_instr(OP_LW, ra[4:0], 5'd0, 16'(idx * 4)));
				end
			endcase
		end
		reset_and_run("random_program", RUN_RAND);
	endtask

	initial
	begin
		arst_n    = 1'b0;
		prog_we   = 1'b0;
		prog_addr = '0;
		prog_data = '0;
		err_count = 0;
		prog_len  = 0;
		lfsr      = 32'hf965fb6a;
		for (int i = 0; i < DMEM_DEPTH; i++)
		begin
			ref_mem[i]       = '0;
			ref_mem_valid[i] = 1'b0;
		end
		repeat (5) @(negedge clk);
		alu_forwarding();
		decode_bypass();
		load_use_stall();
		load_store_copy();
		zero_register();
		random_program();
		$display("errors: %0d", err_count);
		if (err_count == 0)
			$display("*** PASSED ***");
		else
			$display("*** FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

// ==== mips_pipe.sv ====
`timescale 1ns/1ns
`default_nettype none

module mips_pipe #(
	parameter int IMEM_DEPTH = 64,
	parameter int DMEM_DEPTH = 64
) (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   prog_we,
	input  logic [29:0]            prog_addr,
	input  logic [31:0]            prog_data,
	output logic                   wb_valid,
	output mips_isa_pkg::reg_idx_t wb_dest,
	output logic [31:0]            wb_data,
	output logic                   st_valid,
	output logic [31:0]            st_addr,
	output logic [31:0]            st_data
);
	import mips_isa_pkg::*;
	import pipe_pkg::*;

	logic [31:0] pc;
	logic [31:0] instr_word;
	logic [31:0] rdata_a;
	logic [31:0] rdata_b;
	logic [31:0] dmem_rdata;
	logic [31:0] store_data;
	reg_idx_t    raddr_a;
	reg_idx_t    raddr_b;
	hazard_t     haz;
	if_id_t      if_id;
	id_ex_t      id_ex;
	id_ex_t      id_ex_next;
	ex_mem_t     ex_mem;
	ex_mem_t     ex_mem_next;
	mem_wb_t     mem_wb;
	mem_wb_t     mem_wb_next;

	// Fetch, held by a load-use stall
	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			pc    <= '0;
			if_id <= '0;
		end
		else if (!haz.stall)
		begin
			pc          <= pc + 32'd4;
			if_id.instr <= instr_word;
		end
	end

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
		begin
			id_ex  <= '0;
			ex_mem <= '0;
			mem_wb <= '0;
		end
		else
		begin
			id_ex  <= id_ex_next;
			ex_mem <= ex_mem_next;
			mem_wb <= mem_wb_next;
		end
	end

	mem_array #(.DEPTH(IMEM_DEPTH)) u_imem (
		.clk   (clk),
		.we    (prog_we && !arst_n),    // Program port, only in reset
		.waddr (prog_addr),
		.wdata (prog_data),
		.raddr (pc[31:2]),
		.rdata (instr_word)
	);

	forward_unit u_fwd (
		.clk    (clk),
		.arst_n (arst_n),
		.if_id  (if_id),
		.id_ex  (id_ex),
		.ex_mem (ex_mem),
		.mem_wb (mem_wb),
		.haz    (haz)
	);

	reg_file u_rf (
		.clk     (clk),
		.arst_n  (arst_n),
		.we      (mem_wb.ctrl.reg_write),
		.waddr   (mem_wb.dest),
		.wdata   (mem_wb.result),
		.raddr_a (raddr_a),
		.raddr_b (raddr_b),
		.rdata_a (rdata_a),
		.rdata_b (rdata_b)
	);

	decode_stage u_dec (
		.if_id      (if_id),
		.haz        (haz),
		.wb         (mem_wb),
		.rdata_a    (rdata_a),
		.rdata_b    (rdata_b),
		.raddr_a    (raddr_a),
		.raddr_b    (raddr_b),
		.id_ex_next (id_ex_next)
	);

	exec_stage u_ex (
		.id_ex         (id_ex),
		.haz           (haz),
		.ex_mem_result (ex_mem.alu_result),
		.wb_result     (mem_wb.result),
		.ex_mem_next   (ex_mem_next)
	);

	assign store_data = haz.mem_to_mem ? mem_wb.result : ex_mem.store_data;

	mem_array #(.DEPTH(DMEM_DEPTH)) u_dmem (
		.clk   (clk),
		.we    (ex_mem.ctrl.mem_write),
		.waddr (ex_mem.alu_result[31:2]),
		.wdata (store_data),
		.raddr (ex_mem.alu_result[31:2]),
		.rdata (dmem_rdata)
	);

	assign mem_wb_next = '{
		ctrl:   ex_mem.ctrl,
		dest:   ex_mem.dest,
		result: ex_mem.ctrl.mem_to_reg ? dmem_rdata : ex_mem.alu_result
	};

	assign wb_valid = mem_wb.ctrl.reg_write && (mem_wb.dest != '0);
	assign wb_dest  = mem_wb.dest;
	assign wb_data  = mem_wb.result;
	assign st_valid = ex_mem.ctrl.mem_write;
	assign st_addr  = ex_mem.alu_result;
	assign st_data  = store_data;

endmodule

`default_nettype wire

// ==== mem_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module mem_array #(
	parameter int DEPTH = 64
) (
	input  logic        clk,
	input  logic        we,
	input  logic [29:0] waddr,
	input  logic [31:0] wdata,
	input  logic [29:0] raddr,
	output logic [31:0] rdata
);
	localparam int AW = $clog2(DEPTH);

	logic [31:0] mem [DEPTH];

	always_ff @(posedge clk)
	begin
		if (we)
			mem[waddr[AW-1:0]] <= wdata;
	end

	assign rdata = mem[raddr[AW-1:0]];    // Word index, async read

	a_waddr_range: assert property (@(posedge clk) we |-> (waddr < DEPTH))
		else $error("write address %0d beyond depth %0d", waddr, DEPTH);

endmodule

`default_nettype wire

// ==== exec_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module exec_stage (
	input  pipe_pkg::id_ex_t  id_ex,
	input  pipe_pkg::hazard_t haz,
	input  logic [31:0]       ex_mem_result,
	input  logic [31:0]       wb_result,
	output pipe_pkg::ex_mem_t ex_mem_next
);
	import pipe_pkg::*;

	logic [31:0] op_a;
	logic [31:0] op_b_fwd;
	logic [31:0] op_b;
	logic [31:0] alu_y;

	always_comb
	begin
		case (haz.fwd_a)
			FWD_EXM: op_a = ex_mem_result;
			FWD_WB:  op_a = wb_result;
			default: op_a = id_ex.op_a;
		endcase

		case (haz.fwd_b)
			FWD_EXM: op_b_fwd = ex_mem_result;
			FWD_WB:  op_b_fwd = wb_result;
			default: op_b_fwd = id_ex.op_b;
		endcase

		op_b = id_ex.ctrl.alu_src_imm ? id_ex.imm : op_b_fwd;

		case (id_ex.ctrl.alu_op)
			ALU_SUB: alu_y = op_a - op_b;
			ALU_AND: alu_y = op_a & op_b;
			ALU_OR:  alu_y = op_a | op_b;
			ALU_SLT: alu_y = {31'd0, $signed(op_a) < $signed(op_b)};
			default: alu_y = op_a + op_b;
		endcase
	end

	assign ex_mem_next = '{
		ctrl:       id_ex.ctrl,
		dest:       id_ex.dest,
		rt:         id_ex.rt,
		alu_result: alu_y,
		store_data: op_b_fwd    // Forwarded rt, not the immediate
	};

endmodule

`default_nettype wire

// ==== decode_stage.sv ====
`timescale 1ns/1ns
`default_nettype none

module decode_stage (
	input  pipe_pkg::if_id_t       if_id,
	input  pipe_pkg::hazard_t      haz,
	input  pipe_pkg::mem_wb_t      wb,
	input  logic [31:0]            rdata_a,
	input  logic [31:0]            rdata_b,
	output mips_isa_pkg::reg_idx_t raddr_a,
	output mips_isa_pkg::reg_idx_t raddr_b,
	output pipe_pkg::id_ex_t       id_ex_next
);
	import mips_isa_pkg::*;
	import pipe_pkg::*;

	instr_t   instr;
	ctrl_t    ctrl;
	reg_idx_t dest;

	assign instr   = if_id.instr;
	assign raddr_a = instr.r.rs;
	assign raddr_b = instr.r.rt;

	always_comb
	begin
		ctrl = '0;
		dest = '0;
		case (instr.r.opcode)
			OP_RTYPE:
			begin
				ctrl.reg_write = 1'b1;
				dest           = instr.r.rd;
				case (instr.r.funct)
					FN_ADD: ctrl.alu_op = ALU_ADD;
					FN_SUB: ctrl.alu_op = ALU_SUB;
					FN_AND: ctrl.alu_op = ALU_AND;
					FN_OR:  ctrl.alu_op = ALU_OR;
					FN_SLT: ctrl.alu_op = ALU_SLT;
					default:
					begin
						ctrl.reg_write = 1'b0;    // nop and unknown funct
						dest           = '0;
					end
				endcase
			end
			OP_ADDI:
			begin
				ctrl.reg_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				dest             = instr.i.rt;
			end
			OP_LW:
			begin
				ctrl.reg_write   = 1'b1;
				ctrl.mem_read    = 1'b1;
				ctrl.mem_to_reg  = 1'b1;
				ctrl.alu_src_imm = 1'b1;
				dest             = instr.i.rt;
			end
			OP_SW:
			begin
				ctrl.mem_write   = 1'b1;
				ctrl.alu_src_imm = 1'b1;
			end
			default: ;
		endcase

		if (haz.stall)
			ctrl = '0;    // Bubble

		id_ex_next.ctrl = ctrl;
		id_ex_next.rs   = instr.r.rs;
		id_ex_next.rt   = instr.r.rt;
		id_ex_next.dest = dest;
		id_ex_next.op_a = haz.id_bypass[0] ? wb.result : rdata_a;
		id_ex_next.op_b = haz.id_bypass[1] ? wb.result : rdata_b;
		id_ex_next.imm  = {{16{instr.i.imm[15]}}, instr.i.imm};
	end

endmodule

`default_nettype wire

// ==== reg_file.sv ====
`timescale 1ns/1ns
`default_nettype none

module reg_file (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   we,
	input  mips_isa_pkg::reg_idx_t waddr,
	input  logic [31:0]            wdata,
	input  mips_isa_pkg::reg_idx_t raddr_a,
	input  mips_isa_pkg::reg_idx_t raddr_b,
	output logic [31:0]            rdata_a,
	output logic [31:0]            rdata_b
);
	logic [31:0] regs [32];

	always_ff @(posedge clk or negedge arst_n)
	begin
		if (!arst_n)
			regs <= '{default: '0};
		else if (we && (waddr != '0))    // r0 is hardwired
			regs[waddr] <= wdata;
	end

	assign rdata_a = regs[raddr_a];
	assign rdata_b = regs[raddr_b];

	a_r0_zero: assert property (@(posedge clk) disable iff (!arst_n)
		(we && (waddr == '0)) |=> (regs[0] == '0))
		else $error("register zero was written");

endmodule

`default_nettype wire

// ==== forward_unit.sv ====
`timescale 1ns/1ns
`default_nettype none

module forward_unit (
	input  logic              clk,
	input  logic              arst_n,
	input  pipe_pkg::if_id_t  if_id,
	input  pipe_pkg::id_ex_t  id_ex,
	input  pipe_pkg::ex_mem_t ex_mem,
	input  pipe_pkg::mem_wb_t mem_wb,
	output pipe_pkg::hazard_t haz
);
	import mips_isa_pkg::*;
	import pipe_pkg::*;

	reg_idx_t id_rs;
	reg_idx_t id_rt;
	logic     id_is_store;
	logic     exm_wr;
	logic     wb_wr;
	logic     wb_is_load;

	assign id_rs       = if_id.instr.r.rs;
	assign id_rt       = if_id.instr.r.rt;
	assign id_is_store = (if_id.instr.i.opcode == OP_SW);
	assign exm_wr      = ex_mem.ctrl.reg_write && (ex_mem.dest != '0);
	assign wb_wr       = mem_wb.ctrl.reg_write && (mem_wb.dest != '0);
	assign wb_is_load  = wb_wr && mem_wb.ctrl.mem_read;

	always_comb
	begin
		if (exm_wr && (ex_mem.dest == id_ex.rs))
			haz.fwd_a = FWD_EXM;
		else if (wb_wr && (mem_wb.dest == id_ex.rs))
			haz.fwd_a = FWD_WB;
		else
			haz.fwd_a = FWD_REG;

		if (exm_wr && (ex_mem.dest == id_ex.rt))
			haz.fwd_b = FWD_EXM;
		else if (wb_wr && (mem_wb.dest == id_ex.rt))
			haz.fwd_b = FWD_WB;
		else
			haz.fwd_b = FWD_REG;

		haz.mem_to_mem = ex_mem.ctrl.mem_write && wb_is_load && (ex_mem.rt == mem_wb.dest);

		// A store of the loaded value is left to the mem-to-mem copy
		haz.stall = id_ex.ctrl.mem_read && (id_ex.dest != '0) &&
			((id_ex.dest == id_rs) || ((id_ex.dest == id_rt) && !id_is_store));

		haz.id_bypass[0] = wb_wr && (mem_wb.dest == id_rs);
		haz.id_bypass[1] = wb_wr && (mem_wb.dest == id_rt);
	end

	// Only a load in EX stalls decode, and for one cycle
	a_stall_load: assert property (@(posedge clk) disable iff (!arst_n)
		haz.stall |-> (id_ex.ctrl.mem_to_reg && !id_ex.ctrl.mem_write) ##1 !haz.stall)
		else $error("load-use stall without load in EX or longer than one cycle");

	// Store data came from the load in EX/MEM one cycle earlier
	a_m2m_store: assert property (@(posedge clk) disable iff (!arst_n)
		haz.mem_to_mem |-> !ex_mem.ctrl.reg_write && mem_wb.ctrl.mem_to_reg &&
			$past(haz.fwd_b == FWD_EXM))
		else $error("mem-to-mem copy without store after load");

endmodule

`default_nettype wire

// ==== pipe_pkg.sv ====
`default_nettype none

package pipe_pkg;

	typedef enum logic [2:0] {
		ALU_ADD,
		ALU_SUB,
		ALU_AND,
		ALU_OR,
		ALU_SLT
	} alu_op_e;

	typedef enum logic [1:0] {
		FWD_REG = 2'd0,
		FWD_WB  = 2'd1,
		FWD_EXM = 2'd2
	} fwd_sel_e;

	typedef struct packed {
		logic    reg_write;
		logic    mem_read;
		logic    mem_write;
		logic    mem_to_reg;
		logic    alu_src_imm;
		alu_op_e alu_op;
	} ctrl_t;

	typedef struct packed {
		mips_isa_pkg::instr_t instr;
	} if_id_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		mips_isa_pkg::reg_idx_t rs;
		mips_isa_pkg::reg_idx_t rt;
		mips_isa_pkg::reg_idx_t dest;
		logic [31:0]            op_a;
		logic [31:0]            op_b;
		logic [31:0]            imm;
	} id_ex_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		mips_isa_pkg::reg_idx_t dest;
		mips_isa_pkg::reg_idx_t rt;    // Store source, for the mem-to-mem copy
		logic [31:0]            alu_result;
		logic [31:0]            store_data;
	} ex_mem_t;

	typedef struct packed {
		ctrl_t                  ctrl;
		mips_isa_pkg::reg_idx_t dest;
		logic [31:0]            result;
	} mem_wb_t;

	typedef struct packed {
		fwd_sel_e   fwd_a;
		fwd_sel_e   fwd_b;
		logic       mem_to_mem;
		logic       stall;
		logic [1:0] id_bypass;    // Bit 0 rs, bit 1 rt
	} hazard_t;

endpackage

`default_nettype wire

// ==== mips_isa_pkg.sv ====
`default_nettype none

package mips_isa_pkg;

	typedef logic [4:0] reg_idx_t;

	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_ADDI  = 6'h08,
		OP_LW    = 6'h23,
		OP_SW    = 6'h2b
	} opcode_e;

	typedef enum logic [5:0] {
		FN_ADD = 6'h20,
		FN_SUB = 6'h22,
		FN_AND = 6'h24,
		FN_OR  = 6'h25,
		FN_SLT = 6'h2a
	} funct_e;

	typedef struct packed {
		opcode_e    opcode;
		reg_idx_t   rs;
		reg_idx_t   rt;
		reg_idx_t   rd;
		logic [4:0] shamt;
		funct_e     funct;
	} r_form_t;

	typedef struct packed {
		opcode_e     opcode;
		reg_idx_t    rs;
		reg_idx_t    rt;
		logic [15:0] imm;
	} i_form_t;

	// Same 32-bit word, two views
	typedef union packed {
		r_form_t r;
		i_form_t i;
	} instr_t;

endpackage

`default_nettype wire
